// File: build.f
verilog/regstate_pkg.sv
verilog/gpr_file.sv
verilog/ctrl_reg_file.sv
verilog/regstate_top.sv
testbench/regstate_asserts.sv
testbench/tb_regstate.sv

// File: Bender.yml
package:
  name: regstate

sources:
  # design, package first
  - verilog/regstate_pkg.sv
  - verilog/gpr_file.sv
  - verilog/ctrl_reg_file.sv
  - verilog/regstate_top.sv

  # verification only
  - target: test
    files:
      - testbench/regstate_asserts.sv
      - testbench/tb_regstate.sv

// File: testbench/tb_regstate.sv
`timescale 1ns/100ps

module tb_regstate;

  import regstate_pkg::*;

  localparam int num_irq        = 16;
  localparam int reset_cycles   = 2;
  localparam int num_cycles     = 2000;
  // reset plus the random run, with some margin for the final checks
  localparam int timeout_cycles = reset_cycles + num_cycles + 98;

  logic                   clk;
  logic                   rst;
  logic                   clk_en;
  logic                   stall;
  logic [gpr_addr_w-1:0]  gpr_raddr0;
  logic [gpr_addr_w-1:0]  gpr_raddr1;
  gpr_write_t             gpr_wr0;
  gpr_write_t             gpr_wr1;
  logic [xlen-1:0]        gpr_rdata0;
  logic [xlen-1:0]        gpr_rdata1;
  logic [xlen-1:0]        ret_val;
  logic [creg_addr_w-1:0] creg_raddr;
  creg_write_t            creg_wr;
  exc_event_t             exc;
  logic [num_irq-1:0]     interrupts;
  logic [xlen-1:0]        creg_rdata;
  creg_status_t           status;

  // reference model state
  logic [xlen-1:0] gpr_model [32];
  logic [xlen-1:0] exp_rdata0;
  logic [xlen-1:0] exp_rdata1;
  logic [xlen-1:0] creg_model [8];
  logic [xlen-1:0] exp_creg_rdata;

  int cycle_count;

  regstate_top #(
    .num_irq (num_irq)
  ) regstate_top_inst (
    .clk        (clk),
    .rst        (rst),
    .clk_en     (clk_en),
    .stall      (stall),
    .gpr_raddr0 (gpr_raddr0),
    .gpr_raddr1 (gpr_raddr1),
    .gpr_wr0    (gpr_wr0),
    .gpr_wr1    (gpr_wr1),
    .gpr_rdata0 (gpr_rdata0),
    .gpr_rdata1 (gpr_rdata1),
    .ret_val    (ret_val),
    .creg_raddr (creg_raddr),
    .creg_wr    (creg_wr),
    .exc        (exc),
    .interrupts (interrupts),
    .creg_rdata (creg_rdata),
    .status     (status)
  );

  always #50 clk = ~clk;

  // run limit
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("Test timed out after %0d cycles", cycle_count);
      $display("SIMULATION FAILED");
      $fatal(1, "cycle limit reached");
    end
  end

  task automatic check_value(input string name, input logic [xlen-1:0] actual,
                             input logic [xlen-1:0] expected);
    if (actual !== expected) begin
      $display("Error: %s is 0x%08h, expected 0x%08h (cycle %0d)",
               name, actual, expected, cycle_count);
      $display("SIMULATION FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // advance the model by one clock edge, using the inputs held during the cycle
  task automatic update_model();
    logic [xlen-1:0] old_cregs [8];
    logic [xlen-1:0] lines;
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        gpr_model[i] = '0;
      end
      for (int i = 0; i < 8; i++) begin
        creg_model[i] = '0;
      end
      creg_model[creg_psr] = 32'd1;
      exp_rdata0     = '0;
      exp_rdata1     = '0;
      exp_creg_rdata = '0;
    end else begin
      // reads see the array before this edge's writes
      if (!stall) begin
        exp_rdata0 = (gpr_raddr0 == 0) ? '0 : gpr_model[gpr_raddr0];
        exp_rdata1 = (gpr_raddr1 == 0) ? '0 : gpr_model[gpr_raddr1];
      end
      if (gpr_wr0.en) begin
        gpr_model[gpr_wr0.addr] = gpr_wr0.data;
      end
      if (gpr_wr1.en) begin
        gpr_model[gpr_wr1.addr] = gpr_wr1.data;
      end

      lines     = {{(xlen-num_irq){1'b0}}, interrupts};
      old_cregs = creg_model;
      if (clk_en && creg_wr.en) begin
        creg_model[creg_wr.addr[2:0]] = creg_wr.data;
      end
      // events override a move to the same register
      if (clk_en && !stall) begin
        if (exc.exc) begin
          creg_model[creg_psr] = old_cregs[creg_psr] + 32'd1;
          creg_model[creg_epc] = exc.epc;
          creg_model[creg_efg] = exc.efg;
          if (exc.tlb_exc) begin
            creg_model[creg_tlb] = exc.tlb_addr;
          end
          if (exc.interrupt) begin
            creg_model[creg_imr] = old_cregs[creg_imr] & 32'h7fff_ffff;
          end
        end else if (exc.rfe) begin
          creg_model[creg_psr] = old_cregs[creg_psr] - 32'd1;
          if (exc.rfi) begin
            creg_model[creg_imr] = old_cregs[creg_imr] | 32'h8000_0000;
          end
        end else if (creg_raddr == 0) begin
          exp_creg_rdata = '0;
        end else begin
          exp_creg_rdata = old_cregs[creg_raddr[2:0]];
        end
      end
      // pending lines stick whether or not clk_en is set
      if (clk_en && creg_wr.en && (creg_wr.addr[2:0] == creg_isr)) begin
        creg_model[creg_isr] = creg_wr.data | lines;
      end else begin
        creg_model[creg_isr] = old_cregs[creg_isr] | lines;
      end
    end
  endtask

  task automatic check_outputs();
    logic [xlen-1:0] exp_istate;
    if (creg_model[creg_imr][31]) begin
      exp_istate = creg_model[creg_isr] & creg_model[creg_imr];
    end else begin
      exp_istate = '0;
    end
    check_value("gpr_rdata0", gpr_rdata0, exp_rdata0);
    check_value("gpr_rdata1", gpr_rdata1, exp_rdata1);
    check_value("ret_val", ret_val, gpr_model[1]);
    check_value("creg_rdata", creg_rdata, exp_creg_rdata);
    check_value("status.kmode", {31'd0, status.kmode},
                {31'd0, (creg_model[creg_psr] != 0)});
    check_value("status.interrupt_state", status.interrupt_state, exp_istate);
    check_value("status.pid", status.pid, creg_model[creg_pid]);
    check_value("status.cdv", status.cdv, creg_model[creg_cdv]);
    check_value("assertion failure count",
                regstate_top_inst.ctrl_reg_file_inst.regstate_asserts_inst.fail_count, 32'd0);
  endtask

  // fixed values straight out of reset
  task automatic check_reset_values();
    check_value("gpr_rdata0", gpr_rdata0, 32'd0);
    check_value("gpr_rdata1", gpr_rdata1, 32'd0);
    check_value("ret_val", ret_val, 32'd0);
    check_value("creg_rdata", creg_rdata, 32'd0);
    check_value("status.kmode", {31'd0, status.kmode}, 32'd1);
    check_value("status.interrupt_state", status.interrupt_state, 32'd0);
    check_value("status.pid", status.pid, 32'd0);
    check_value("status.cdv", status.cdv, 32'd0);
  endtask

  task automatic drive_random();
    int unsigned pick;
    gpr_raddr0   = gpr_addr_w'($urandom_range(31, 0));
    gpr_raddr1   = gpr_addr_w'($urandom_range(31, 0));
    gpr_wr0.en   = ($urandom_range(99, 0) < 50);
    gpr_wr0.addr = gpr_addr_w'($urandom_range(31, 0));
    gpr_wr0.data = $urandom();
    gpr_wr1.en   = ($urandom_range(99, 0) < 30);
    gpr_wr1.addr = gpr_addr_w'($urandom_range(31, 0));
    gpr_wr1.data = $urandom();
    // now and then both ports hit one register
    if ($urandom_range(9, 0) == 0) begin
      gpr_wr0.en   = 1'b1;
      gpr_wr1.en   = 1'b1;
      gpr_wr1.addr = gpr_wr0.addr;
    end
    stall  = ($urandom_range(99, 0) < 20);
    clk_en = ($urandom_range(99, 0) < 90);

    creg_raddr   = creg_addr_w'($urandom_range(31, 0));
    creg_wr.en   = ($urandom_range(99, 0) < 30);
    creg_wr.addr = {2'($urandom_range(3, 0)), 3'($urandom_range(7, 1))};
    creg_wr.data = $urandom();

    // sparse interrupt lines
    interrupts = '0;
    if ($urandom_range(7, 0) == 0) begin
      interrupts[$urandom_range(num_irq - 1, 0)] = 1'b1;
    end

    pick          = $urandom_range(99, 0);
    exc.exc       = (pick < 5);
    exc.rfe       = (pick >= 5) && (pick < 10);
    exc.tlb_exc   = 1'($urandom_range(1, 0));
    exc.interrupt = 1'($urandom_range(1, 0));
    exc.rfi       = 1'($urandom_range(1, 0));
    exc.tlb_addr  = $urandom();
    exc.epc       = $urandom();
    exc.efg       = $urandom();
  endtask

  initial begin
    void'($urandom(32'hc220925f));
    cycle_count = 0;
    clk         = 1'b0;
    rst         = 1'b1;
    clk_en      = 1'b0;
    stall       = 1'b0;
    gpr_raddr0  = '0;
    gpr_raddr1  = '0;
    gpr_wr0     = '0;
    gpr_wr1     = '0;
    creg_raddr  = '0;
    creg_wr     = '0;
    exc         = '0;
    interrupts  = '0;

    repeat (reset_cycles) begin
      @(posedge clk);
      update_model();
    end
    #1;
    check_reset_values();
    check_outputs();
    rst = 1'b0;
    drive_random();

    repeat (num_cycles) begin
      @(posedge clk);
      update_model();
      #1;
      check_outputs();
      drive_random();
    end

    if (regstate_top_inst.ctrl_reg_file_inst.regstate_asserts_inst.fail_count == 0) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      $display("A concurrent assertion on the control registers failed");
      $display("SIMULATION FAILED");
      $fatal(1, "assertion failures present");
    end
  end

endmodule

// File: testbench/regstate_asserts.sv
`timescale 1ns/100ps

module regstate_asserts (
  input logic                          clk,
  input logic                          rst,
  input logic [regstate_pkg::xlen-1:0] psr,
  input logic [regstate_pkg::xlen-1:0] imr,
  input regstate_pkg::creg_status_t    status
);

  import regstate_pkg::*;

  // failures so far, polled by the testbench
  int fail_count = 0;

  kmode_follows_psr: assert property (@(posedge clk) disable iff (rst)
    status.kmode == (psr != '0))
  else begin
    fail_count++;
    $error("kmode does not match psr");
  end

  // global enable off means no interrupt is visible
  irq_masked_when_disabled: assert property (@(posedge clk) disable iff (rst)
    !imr[xlen-1] |-> (status.interrupt_state == '0))
  else begin
    fail_count++;
    $error("interrupt_state nonzero with imr bit 31 clear");
  end

  psr_after_reset: assert property (@(posedge clk)
    rst |=> (psr == psr_reset))
  else begin
    fail_count++;
    $error("psr not at its reset value after reset");
  end

endmodule

bind ctrl_reg_file regstate_asserts regstate_asserts_inst (
  .clk    (clk),
  .rst    (rst),
  .psr    (cregs[regstate_pkg::creg_psr]),
  .imr    (cregs[regstate_pkg::creg_imr]),
  .status (status)
);

// File: verilog/regstate_top.sv
`timescale 1ns/100ps

module regstate_top #(
  parameter int num_irq = 16
) (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 clk_en,
  input  logic                                 stall,

  // general register ports
  input  logic [regstate_pkg::gpr_addr_w-1:0]  gpr_raddr0,
  input  logic [regstate_pkg::gpr_addr_w-1:0]  gpr_raddr1,
  input  regstate_pkg::gpr_write_t             gpr_wr0,
  input  regstate_pkg::gpr_write_t             gpr_wr1,
  output logic [regstate_pkg::xlen-1:0]        gpr_rdata0,
  output logic [regstate_pkg::xlen-1:0]        gpr_rdata1,
  output logic [regstate_pkg::xlen-1:0]        ret_val,

  // control register ports
  input  logic [regstate_pkg::creg_addr_w-1:0] creg_raddr,
  input  regstate_pkg::creg_write_t            creg_wr,
  input  regstate_pkg::exc_event_t             exc,
  input  logic [num_irq-1:0]                   interrupts,
  output logic [regstate_pkg::xlen-1:0]        creg_rdata,
  output regstate_pkg::creg_status_t           status
);

  // general purpose registers, not gated by clk_en
  gpr_file gpr_file_inst (
    .clk     (clk),
    .rst     (rst),
    .stall   (stall),
    .raddr0  (gpr_raddr0),
    .raddr1  (gpr_raddr1),
    .wr0     (gpr_wr0),
    .wr1     (gpr_wr1),
    .rdata0  (gpr_rdata0),
    .rdata1  (gpr_rdata1),
    .ret_val (ret_val)
  );

  // control registers with exception and interrupt bookkeeping
  ctrl_reg_file #(
    .num_irq (num_irq)
  ) ctrl_reg_file_inst (
    .clk        (clk),
    .rst        (rst),
    .clk_en     (clk_en),
    .stall      (stall),
    .raddr      (creg_raddr),
    .wr         (creg_wr),
    .exc        (exc),
    .interrupts (interrupts),
    .rdata      (creg_rdata),
    .status     (status)
  );

endmodule

// File: verilog/ctrl_reg_file.sv
`timescale 1ns/100ps

module ctrl_reg_file #(
  parameter int num_irq = 16
) (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 clk_en,
  input  logic                                 stall,
  input  logic [regstate_pkg::creg_addr_w-1:0] raddr,
  input  regstate_pkg::creg_write_t            wr,
  input  regstate_pkg::exc_event_t             exc,
  input  logic [num_irq-1:0]                   interrupts,
  output logic [regstate_pkg::xlen-1:0]        rdata,
  output regstate_pkg::creg_status_t           status
);

  import regstate_pkg::*;

  localparam int num_cregs = 8;

  logic [xlen-1:0] cregs [num_cregs];

  logic [2:0]      wr_sel;
  logic [2:0]      rd_sel;
  logic [xlen-1:0] irq_lines;
  logic            isr_write;
  logic [xlen-1:0] isr_next;
  logic [xlen-1:0] imr_cur;

  assign wr_sel  = wr.addr[2:0];
  assign rd_sel  = raddr[2:0];
  assign imr_cur = cregs[creg_imr];

  // interrupt lines widened to a full word
  assign irq_lines = xlen'(interrupts);

  // pending interrupts are sticky and latch even with clk_en low
  assign isr_write = clk_en && wr.en && (wr_sel == creg_isr);

  always_comb begin
    if (isr_write) begin
      isr_next = wr.data | irq_lines;
    end else begin
      isr_next = cregs[creg_isr] | irq_lines;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < num_cregs; i++) begin
        if (i == int'(creg_psr)) begin
          cregs[i] <= psr_reset;
        end else begin
          cregs[i] <= '0;
        end
      end
      rdata <= '0;
    end else begin
      // plain moves to control registers
      if (clk_en && wr.en) begin
        cregs[wr_sel] <= wr.data;
      end

      // events come after the move so their update takes priority
      if (clk_en && !stall) begin
        if (exc.exc) begin
          // exception entry, read data holds this cycle
          cregs[creg_psr] <= cregs[creg_psr] + xlen'(1);
          cregs[creg_epc] <= exc.epc;
          cregs[creg_efg] <= exc.efg;
          if (exc.tlb_exc) begin
            cregs[creg_tlb] <= exc.tlb_addr;
          end
          if (exc.interrupt) begin
            // mask off global interrupt enable
            cregs[creg_imr] <= {1'b0, imr_cur[xlen-2:0]};
          end
        end else if (exc.rfe) begin
          // return from exception
          cregs[creg_psr] <= cregs[creg_psr] - xlen'(1);
          if (exc.rfi) begin
            cregs[creg_imr] <= {1'b1, imr_cur[xlen-2:0]};
          end
        end else begin
          if (raddr == '0) begin
            rdata <= '0;
          end else begin
            rdata <= cregs[rd_sel];
          end
        end
      end

      cregs[creg_isr] <= isr_next;
    end
  end

  // status is a pure function of the register contents
  always_comb begin
    status.kmode = (cregs[creg_psr] != '0);
    // imr bit 31 is the global interrupt enable
    if (imr_cur[xlen-1]) begin
      status.interrupt_state = cregs[creg_isr] & imr_cur;
    end else begin
      status.interrupt_state = '0;
    end
    status.pid = cregs[creg_pid];
    status.cdv = cregs[creg_cdv];
  end

endmodule

// File: verilog/gpr_file.sv
`timescale 1ns/100ps

module gpr_file (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                stall,
  input  logic [regstate_pkg::gpr_addr_w-1:0] raddr0,
  input  logic [regstate_pkg::gpr_addr_w-1:0] raddr1,
  input  regstate_pkg::gpr_write_t            wr0,
  input  regstate_pkg::gpr_write_t            wr1,
  output logic [regstate_pkg::xlen-1:0]       rdata0,
  output logic [regstate_pkg::xlen-1:0]       rdata1,
  output logic [regstate_pkg::xlen-1:0]       ret_val
);

  import regstate_pkg::*;

  localparam int num_regs = 2 ** gpr_addr_w;

  logic [xlen-1:0] regs [num_regs];

  // r1 carries the return value by convention
  assign ret_val = regs[1];

  // register array, written in port order
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (wr0.en) begin
        regs[wr0.addr] <= wr0.data;
      end
      // port 1 carries the pre/post increment address update,
      // placed last so it wins a collision with port 0
      if (wr1.en) begin
        regs[wr1.addr] <= wr1.data;
      end
    end
  end

  // registered read ports, sampled before this edge's writes land
  always_ff @(posedge clk) begin
    if (rst) begin
      rdata0 <= '0;
      rdata1 <= '0;
    end else if (!stall) begin
      // r0 is hardwired to zero on reads
      if (raddr0 == '0) begin
        rdata0 <= '0;
      end else begin
        rdata0 <= regs[raddr0];
      end
      if (raddr1 == '0) begin
        rdata1 <= '0;
      end else begin
        rdata1 <= regs[raddr1];
      end
    end
  end

endmodule

// File: verilog/regstate_pkg.sv
package regstate_pkg;

  // machine word and register file geometry
  localparam int xlen        = 32;
  localparam int gpr_addr_w  = 5;
  // only the low three bits pick a control register
  localparam int creg_addr_w = 5;

  // control register indices
  localparam logic [2:0] creg_psr = 3'd0;
  localparam logic [2:0] creg_pid = 3'd1;
  localparam logic [2:0] creg_isr = 3'd2;
  localparam logic [2:0] creg_imr = 3'd3;
  localparam logic [2:0] creg_epc = 3'd4;
  localparam logic [2:0] creg_efg = 3'd5;
  localparam logic [2:0] creg_cdv = 3'd6;
  localparam logic [2:0] creg_tlb = 3'd7;

  // core comes out of reset in kernel mode
  localparam logic [xlen-1:0] psr_reset = xlen'(1);

  // one general register write port
  typedef struct packed {
    logic                  en;
    logic [gpr_addr_w-1:0] addr;
    logic [xlen-1:0]       data;
  } gpr_write_t;

  // move to a control register
  typedef struct packed {
    logic                   en;
    logic [creg_addr_w-1:0] addr;
    logic [xlen-1:0]        data;
  } creg_write_t;

  // exception or return event seen in writeback
  typedef struct packed {
    logic            exc;
    logic            tlb_exc;
    logic            interrupt;
    logic            rfe;
    logic            rfi;
    logic [xlen-1:0] tlb_addr;
    logic [xlen-1:0] epc;
    logic [xlen-1:0] efg;
  } exc_event_t;

  // status seen by the rest of the core
  typedef struct packed {
    logic            kmode;
    logic [xlen-1:0] interrupt_state;
    logic [xlen-1:0] pid;
    logic [xlen-1:0] cdv;
  } creg_status_t;

endpackage
